//--- include/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Width of instruction words and addresses.
`define XLEN 32

// First fetch address after reset.
`define RESET_PC 32'h0000_0000

// Position of the Thumb flag in the CPSR.
`define CPSR_T 5

// Instruction word on an abort or after a clear.
// Decodes as ANDEQ R0, R0, R0 in ARM state.
`define ABORT_PAYLOAD 32'h0000_0000

`endif

//--- rtl/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

        // One answer from the instruction cache.
        typedef struct packed {
                logic [31:0]       instruction;   // Fetched word.
                logic              valid;         // Word is good.
                logic              abort;         // Instruction abort on this address.
        } cache_resp_t;

        // One entry of the fetch buffer.
        typedef struct packed {
                logic [31:0]       instruction;   // Buffered word.
                logic              valid;         // Entry holds an instruction.
                logic              abort;         // Entry is an abort marker.
                logic [`XLEN-1:0]  pc;            // Address of the word.
                logic [`XLEN-1:0]  pc_plus_8;     // PC+8, or PC+4 in Thumb state.
        } fetch_out_t;

        // Front end redirect with its new fetch address.
        typedef struct packed {
                logic              valid;         // Redirect this cycle.
                logic [`XLEN-1:0]  target;        // Where fetch goes next.
        } redirect_t;

        // Record leaving the pre-decoder.
        typedef struct packed {
                logic              valid;         // Record is live.
                logic [`XLEN-1:0]  pc;            // Address of the instruction.
                logic [31:0]       instruction;   // Instruction word.
                logic              abort;         // Abort marker.
                logic              is_branch;     // Unconditional branch seen.
        } decoded_t;

endpackage

//--- rtl/pc_sequencer.sv
`include "fetch_settings.svh"

module pc_sequencer
(
        input  logic                  i_clk,            // Core clock.
        input  logic                  i_reset,          // Synchronous, active high.

        // Redirects, writeback first.
        input  fetch_pkg::redirect_t  i_wb_redirect,    // Clear from writeback.
        input  fetch_pkg::redirect_t  i_dec_redirect,   // Branch seen by pre-decode.

        // Back-pressure.
        input  logic                  i_data_stall,     // Data side busy.
        input  logic                  i_decode_stall,   // Decode busy.

        input  logic [`XLEN-1:0]      i_cpsr,           // Current CPSR.
        output logic [`XLEN-1:0]      o_pc              // Fetch address.
);

// Fetch program counter.
logic [`XLEN-1:0] pc_ff;

// Sequential increment for the current state.
logic [`XLEN-1:0] pc_step;

// Either stall freezes the address.
logic             hold;

// Halfword steps in Thumb state.
assign pc_step = i_cpsr[`CPSR_T] ? `XLEN'(2) : `XLEN'(4);
assign hold    = i_data_stall | i_decode_stall;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff <= `RESET_PC;                     // Start of program.
        end
        else if (i_wb_redirect.valid)
        begin
                pc_ff <= i_wb_redirect.target;          // Writeback beats everything.
        end
        else if (hold)
        begin
                pc_ff <= pc_ff;                         // Same address again.
        end
        else if (i_dec_redirect.valid)
        begin
                pc_ff <= i_dec_redirect.target;         // Branch target.
        end
        else
        begin
                // Keeps stepping even while the buffer sleeps.
                pc_ff <= pc_ff + pc_step;
        end
end

// Address goes straight to the cache.
assign o_pc = pc_ff;

endmodule

//--- rtl/fetch_main.sv
`include "fetch_settings.svh"

module fetch_main
(
        input  logic                    i_clk,                  // Core clock.
        input  logic                    i_reset,                // Synchronous, active high.

        // Clears and stalls, high priority first.
        input  logic                    i_clear_from_writeback, // Flush and wake.
        input  logic                    i_data_stall,           // Freeze.
        input  logic                    i_stall_from_decode,    // Freeze.
        input  logic                    i_clear_from_decode,    // Flush and wake.

        input  logic [`XLEN-1:0]        i_pc_ff,                // Address being fetched.
        input  logic [`XLEN-1:0]        i_cpsr_ff,              // CPSR for the step size.

        input  fetch_pkg::cache_resp_t  i_resp,                 // Same cycle cache answer.
        output fetch_pkg::fetch_out_t   o_fetch                 // Buffered entry.
);

import fetch_pkg::*;

// Set by a loaded abort. Cleared only by a clear.
logic             sleep_ff;

// Distance from PC to the architectural read value.
logic [`XLEN-1:0] pc_ahead;

assign pc_ahead = i_cpsr_ff[`CPSR_T] ? `XLEN'(4) : `XLEN'(8);

// Entry with its payload knocked out. Addresses stay.
function automatic fetch_out_t kill_entry(input fetch_out_t entry);
        fetch_out_t killed;
        killed             = entry;
        killed.valid       = 1'b0;
        killed.abort       = 1'b0;
        killed.instruction = `ABORT_PAYLOAD;
        return killed;
endfunction

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_fetch.valid     <= 1'b0;
                o_fetch.abort     <= 1'b0;
                o_fetch.pc_plus_8 <= `XLEN'(8);
                sleep_ff          <= 1'b0;                      // Awake.
        end
        else if (i_clear_from_writeback)
        begin
                o_fetch  <= kill_entry(o_fetch);
                sleep_ff <= 1'b0;                               // Wake up.
        end
        else if (i_data_stall | i_stall_from_decode)
        begin
                o_fetch  <= o_fetch;                            // Hold everything.
                sleep_ff <= sleep_ff;
        end
        else if (i_clear_from_decode)
        begin
                // Wrong-path word of a taken branch.
                o_fetch  <= kill_entry(o_fetch);
                sleep_ff <= 1'b0;
        end
        else if (sleep_ff)
        begin
                o_fetch  <= kill_entry(o_fetch);                // Bubbles only.
        end
        else
        begin
                o_fetch.instruction <= i_resp.instruction;
                o_fetch.valid       <= i_resp.valid;
                o_fetch.abort       <= i_resp.abort;
                o_fetch.pc          <= i_pc_ff;
                o_fetch.pc_plus_8   <= i_pc_ff + pc_ahead;      // Pipelined PC read value.
                sleep_ff            <= i_resp.abort;            // Doze after an abort.
        end
end

endmodule

//--- rtl/branch_predecode.sv
`include "fetch_settings.svh"

module branch_predecode
(
        input  logic                   i_clk,          // Core clock.
        input  logic                   i_reset,        // Synchronous, active high.
        input  logic                   i_stall,        // Decode stall.

        input  fetch_pkg::fetch_out_t  i_fetch,        // Entry from the fetch buffer.
        input  logic [`XLEN-1:0]       i_cpsr,         // Current CPSR.

        output fetch_pkg::redirect_t   o_redirect,     // Branch redirect.
        output fetch_pkg::decoded_t    o_decoded       // Outgoing record.
);

import fetch_pkg::*;

// Registered redirect. Lives one cycle unless a stall parks it.
redirect_t        redirect_ff;

logic             thumb;                // Thumb state.
logic [31:0]      instr;                // Word under inspection.
logic             arm_branch;           // B with AL condition.
logic             thumb_branch;         // Unconditional 11-bit B.
logic             is_branch;            // Taken branch on a live entry.
logic [`XLEN-1:0] arm_offset;           // imm24 << 2, sign extended.
logic [`XLEN-1:0] thumb_offset;         // imm11 << 1, sign extended.
logic [`XLEN-1:0] target;               // Branch destination.

assign thumb = i_cpsr[`CPSR_T];
assign instr = i_fetch.instruction;

// Cond = 1110, 101 class, L bit low.
assign arm_branch   = (instr[31:28] == 4'hE) && (instr[27:25] == 3'b101) && !instr[24];

// Format 18 branch in the low halfword.
assign thumb_branch = (instr[15:11] == 5'b11100);

assign arm_offset   = {{(`XLEN-26){instr[23]}}, instr[23:0], 2'b00};
assign thumb_offset = {{(`XLEN-12){instr[10]}}, instr[10:0], 1'b0};

// Aborted entries carry no instruction.
assign is_branch = i_fetch.valid && !i_fetch.abort && (thumb ? thumb_branch : arm_branch);

// pc_plus_8 already holds PC+4 in Thumb state.
assign target = i_fetch.pc_plus_8 + (thumb ? thumb_offset : arm_offset);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                redirect_ff.valid <= 1'b0;
                o_decoded.valid   <= 1'b0;
        end
        else if (i_stall)
        begin
                // Fetch holds its entry, so nothing new to take.
                o_decoded.valid   <= 1'b0;
        end
        else if (redirect_ff.valid)
        begin
                redirect_ff.valid <= 1'b0;              // Redirect taken this edge.
                o_decoded.valid   <= 1'b0;              // Drop the wrong-path entry.
        end
        else
        begin
                o_decoded.valid       <= i_fetch.valid | i_fetch.abort;
                o_decoded.pc          <= i_fetch.pc;
                o_decoded.instruction <= i_fetch.instruction;
                o_decoded.abort       <= i_fetch.abort;
                o_decoded.is_branch   <= is_branch;
                redirect_ff.valid     <= is_branch;     // Alongside the branch record.
                redirect_ff.target    <= target;
        end
end

// A parked redirect shows once the stall lifts.
always_comb
begin
        o_redirect       = redirect_ff;
        o_redirect.valid = redirect_ff.valid & ~i_stall;
end

endmodule

//--- rtl/fetch_top.sv
`include "fetch_settings.svh"

module fetch_top
(
        input  logic                    i_clk,            // Core clock.
        input  logic                    i_reset,          // Synchronous, active high.
        input  fetch_pkg::redirect_t    i_wb_redirect,    // Writeback clear with target.
        input  logic                    i_data_stall,     // Data side stall.
        input  logic                    i_decode_stall,   // Decode stall.
        input  logic [`XLEN-1:0]        i_cpsr,           // Current CPSR.
        input  fetch_pkg::cache_resp_t  i_cache_resp,     // Same cycle cache answer.
        output logic [`XLEN-1:0]        o_fetch_addr,     // Address to the cache.
        output fetch_pkg::decoded_t     o_decoded         // Pre-decoded stream.
);

import fetch_pkg::*;

fetch_out_t fetch_entry;        // Buffer to pre-decode.
redirect_t  dec_redirect;       // Pre-decode back to the front end.

pc_sequencer u_pc_sequencer
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_wb_redirect          (i_wb_redirect),
        .i_dec_redirect         (dec_redirect),
        .i_data_stall           (i_data_stall),
        .i_decode_stall         (i_decode_stall),
        .i_cpsr                 (i_cpsr),
        .o_pc                   (o_fetch_addr)
);

fetch_main u_fetch_main
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_wb_redirect.valid),
        .i_data_stall           (i_data_stall),
        .i_stall_from_decode    (i_decode_stall),
        .i_clear_from_decode    (dec_redirect.valid),    // Decode clear.
        .i_pc_ff                (o_fetch_addr),
        .i_cpsr_ff              (i_cpsr),
        .i_resp                 (i_cache_resp),
        .o_fetch                (fetch_entry)
);

// Both stalls freeze the buffer, so both freeze pre-decode.
branch_predecode u_branch_predecode
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_stall                (i_data_stall | i_decode_stall),
        .i_fetch                (fetch_entry),
        .i_cpsr                 (i_cpsr),
        .o_redirect             (dec_redirect),
        .o_decoded              (o_decoded)
);

endmodule

//--- test/fetch_checker.sv
`include "fetch_settings.svh"

module fetch_checker
(
        input  logic                 i_clk,            // Testbench clock.
        input  logic                 i_reset,          // Synchronous, active high.
        input  fetch_pkg::decoded_t  i_decoded,        // DUT output stream.
        output int                   o_error_count,    // Field mismatches.
        output int                   o_extra_count,    // Records beyond the list.
        output int                   o_abort_count,    // Abort records seen.
        output int                   o_record_count    // Records matched in order.
);

timeunit 1ns;
timeprecision 1ps;

import fetch_pkg::*;

// Expected stream, filled once by the testbench.
decoded_t expected_q[$];

task automatic push_expected(input decoded_t rec);
        expected_q.push_back(rec);
endtask

// Compare at the falling edge, where o_decoded is settled.
always @(negedge i_clk)
begin : compare_stream
        decoded_t exp_rec;
        int       field_errors;                         // Mismatches in this record.
        field_errors = 0;
        if (i_reset)
        begin
                o_error_count  <= 0;
                o_extra_count  <= 0;
                o_abort_count  <= 0;
                o_record_count <= 0;
        end
        else if (i_decoded.valid)
        begin
                if (o_record_count >= expected_q.size())
                begin
                        // Nothing left to match against.
                        $display("%0d ns: unexpected extra record at pc %h", $time, i_decoded.pc);
                        o_extra_count <= o_extra_count + 1;
                end
                else
                begin
                        exp_rec = expected_q[o_record_count];
                        if (i_decoded.pc !== exp_rec.pc)
                        begin
                                $display("[ERROR] %0d ns o_decoded.pc: expected %h, got %h",
                                         $time, exp_rec.pc, i_decoded.pc);
                                field_errors++;
                        end
                        if (i_decoded.instruction !== exp_rec.instruction)
                        begin
                                $display("[ERROR] %0d ns o_decoded.instruction: expected %h, got %h",
                                         $time, exp_rec.instruction, i_decoded.instruction);
                                field_errors++;
                        end
                        if (i_decoded.abort !== exp_rec.abort)
                        begin
                                $display("[ERROR] %0d ns o_decoded.abort: expected %b, got %b",
                                         $time, exp_rec.abort, i_decoded.abort);
                                field_errors++;
                        end
                        if (i_decoded.is_branch !== exp_rec.is_branch)
                        begin
                                $display("[ERROR] %0d ns o_decoded.is_branch: expected %b, got %b",
                                         $time, exp_rec.is_branch, i_decoded.is_branch);
                                field_errors++;
                        end
                        o_error_count  <= o_error_count + field_errors;
                        o_record_count <= o_record_count + 1;   // Next expected entry.
                end
                if (i_decoded.abort)
                begin
                        o_abort_count <= o_abort_count + 1;     // Drives writeback timing.
                end
        end
end

endmodule

//--- test/fetch_tb.sv
`include "fetch_settings.svh"

module fetch_tb;

timeunit 1ns;
timeprecision 1ps;

import fetch_pkg::*;

logic        clk;
logic        reset;
redirect_t   wb_redirect;
logic        data_stall;
logic        decode_stall;
logic [31:0] cpsr;
cache_resp_t cache_resp;
logic [31:0] fetch_addr;
decoded_t    decoded;

logic [31:0] mem [logic [31:0]];       // Program image.
bit          abort_map [logic [31:0]]; // Addresses that abort.
int          wb_after [$];             // Abort record count that triggers each redirect.
logic [31:0] wb_target [$];
logic [31:0] wb_cpsr [$];
int          expected_total;
int          other_errors;
logic        stall_enable;
logic [31:0] lfsr;
int          error_count, extra_count, abort_count, record_count;

always #50 clk = ~clk;                 // 100 ns period.

// Galois LFSR, one step per bit.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
                n = n ^ 32'h8020_0003;
        end
        return n;
endfunction

task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
endtask

// Same cycle instruction cache.
function automatic cache_resp_t cache_lookup(input logic [31:0] addr);
        cache_resp_t r;
        r.valid       = 1'b1;
        r.abort       = 1'b0;
        r.instruction = addr ^ 32'hF0F0_0000;           // Fill, never a branch.
        if (abort_map.exists(addr))
        begin
                r.valid       = 1'b0;
                r.abort       = 1'b1;
                r.instruction = `ABORT_PAYLOAD;
        end
        else if (mem.exists(addr))
        begin
                r.instruction = mem[addr];
        end
        return r;
endfunction

always_comb cache_resp = cache_lookup(fetch_addr);

// Random back-pressure once enabled.
always @(posedge clk)
begin : stall_drive
        logic b0, b1, b2, b3;
        if (stall_enable)
        begin
                take_bit(b0);
                take_bit(b1);
                take_bit(b2);
                take_bit(b3);
                data_stall   <= b0 & b1;
                decode_stall <= b2 & b3;
        end
        else
        begin
                data_stall   <= 1'b0;
                decode_stall <= 1'b0;
        end
end

task automatic read_stim();
        int          fd;
        string       line;
        string       rest;
        byte         kind;
        logic [31:0] a, b, c, d;
        decoded_t    rec;
        fd = $fopen("test/fetch_stim.txt", "r");
        if (fd == 0)
        begin
                $display("Could not open test/fetch_stim.txt");
                other_errors++;
                return;
        end
        while ($fgets(line, fd) > 0)
        begin
                if (line.len() < 3)
                begin
                        continue;
                end
                kind = line.getc(0);
                rest = line.substr(2, line.len() - 1);
                if (kind == "M" && $sscanf(rest, "%h %h", a, b) == 2)
                begin
                        mem[a] = b;
                end
                else if (kind == "A" && $sscanf(rest, "%h", a) == 1)
                begin
                        abort_map[a] = 1'b1;
                end
                else if (kind == "W" && $sscanf(rest, "%h %h %h", a, b, c) == 3)
                begin
                        wb_after.push_back(int'(a));
                        wb_target.push_back(b);
                        wb_cpsr.push_back(c);
                end
                else if (kind == "E" && $sscanf(rest, "%h %h %h %h", a, b, c, d) == 4)
                begin
                        rec = '{valid: 1'b1, pc: a, instruction: b,
                                abort: c[0], is_branch: d[0]};
                        u_checker.push_expected(rec);
                        expected_total++;
                end
        end
        $fclose(fd);
endtask

fetch_top UUT
(
        .i_clk          (clk),
        .i_reset        (reset),
        .i_wb_redirect  (wb_redirect),
        .i_data_stall   (data_stall),
        .i_decode_stall (decode_stall),
        .i_cpsr         (cpsr),
        .i_cache_resp   (cache_resp),
        .o_fetch_addr   (fetch_addr),
        .o_decoded      (decoded)
);

fetch_checker u_checker
(
        .i_clk          (clk),
        .i_reset        (reset),
        .i_decoded      (decoded),
        .o_error_count  (error_count),
        .o_extra_count  (extra_count),
        .o_abort_count  (abort_count),
        .o_record_count (record_count)
);

initial
begin : main
        int cycles;
        int missing;
        clk            = 1'b0;
        reset          = 1'b1;
        wb_redirect    = '0;
        data_stall     = 1'b0;
        decode_stall   = 1'b0;
        cpsr           = 32'h0000_0010;                 // ARM state.
        stall_enable   = 1'b0;
        lfsr           = 32'hdd48_53cd;
        expected_total = 0;
        other_errors   = 0;
        read_stim();
        if (other_errors == 0)
        begin
                repeat (3) @(posedge clk);
                reset <= 1'b0;
                // First record two cycles after release.
                cycles = 0;
                while (cycles < 20)
                begin
                        @(posedge clk);
                        cycles++;
                        @(negedge clk);
                        if (decoded.valid)
                        begin
                                break;
                        end
                end
                if (cycles != 2)
                begin
                        $display("First record came %0d cycles after reset, expected 2", cycles);
                        other_errors++;
                end
                for (int i = 0; i < wb_after.size(); i++)
                begin
                        cycles = 0;
                        while (abort_count < wb_after[i] && cycles < 500)
                        begin
                                @(posedge clk);
                                cycles++;
                        end
                        if (abort_count < wb_after[i])
                        begin
                                $display("Timed out waiting for abort record %0d", wb_after[i]);
                                other_errors++;
                        end
                        @(posedge clk);
                        wb_redirect <= '{valid: 1'b1, target: wb_target[i]};
                        cpsr        <= wb_cpsr[i];             // Mode switch with the flush.
                        @(posedge clk);
                        wb_redirect  <= '0;
                        stall_enable <= 1'b1;                   // Stalls from here on.
                end
                cycles = 0;
                while (record_count < expected_total && cycles < 1000)
                begin
                        @(posedge clk);
                        cycles++;
                end
                if (record_count < expected_total)
                begin
                        $display("Timed out waiting for the expected record stream");
                end
                repeat (30) @(posedge clk);                     // Catch stray records.
        end
        missing = expected_total - record_count;
        if (missing > 0)
        begin
                $display("%0d expected records never appeared", missing);
        end
        $display("Errors: mismatch %0d, extra %0d, missing %0d, other %0d",
                 error_count, extra_count, missing, other_errors);
        if (error_count + extra_count + missing + other_errors == 0)
        begin
                $display("TEST PASSED");
        end
        else
        begin
                $display("TEST FAILED");
        end
        $finish;
end

endmodule

//--- vlog.f
+incdir+include
rtl/fetch_pkg.sv
rtl/pc_sequencer.sv
rtl/fetch_main.sv
rtl/branch_predecode.sv
rtl/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch front end with Verilator and runs the testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_tb -f vlog.f -o fetch_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed, see build.log"
        exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status, see sim.log"
        exit 1
fi

cat sim.log

if grep -q "TEST FAILED" sim.log; then
        echo "Simulation reported failure"
        exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- test/fetch_stim.txt
// M addr word | A addr (abort) | W abort_count target cpsr | E pc instr abort is_branch
// All fields hex. Program runs ARM, then Thumb, then ARM again.
M 00000000 E3A01001
M 00000004 E2811001
M 00000008 E2811001
M 0000000C EA000002
M 00000010 E3A020FF
M 0000001C E1A00000
M 00000020 E2811001
A 00000024
W 1 00000100 00000030
M 00000100 00002001
M 00000102 00003001
M 00000104 0000E002
M 00000106 00002002
M 0000010C 00003101
A 0000010E
W 2 00000200 00000010
M 00000200 E3A03003
M 00000204 EA000000
M 00000208 E3A040FF
M 0000020C E2833001
A 00000210
E 00000000 E3A01001 0 0
E 00000004 E2811001 0 0
E 00000008 E2811001 0 0
E 0000000C EA000002 0 1
E 0000001C E1A00000 0 0
E 00000020 E2811001 0 0
E 00000024 00000000 1 0
E 00000100 00002001 0 0
E 00000102 00003001 0 0
E 00000104 0000E002 0 1
E 0000010C 00003101 0 0
E 0000010E 00000000 1 0
E 00000200 E3A03003 0 0
E 00000204 EA000000 0 1
E 0000020C E2833001 0 0
E 00000210 00000000 1 0
